//--- common/eth_bridge_cfg.svh
`ifndef ETH_BRIDGE_CFG_SVH
`define ETH_BRIDGE_CFG_SVH

// Words in the frame store, 4 kB
`define BR_BUF_WORDS 1024

// Length queue depth, enough for a store full of short frames
`define BR_LEN_DEPTH 64

// Free words needed before a new frame is accepted
`define BR_MAX_FRAME_WORDS 383

// Word queue in front of the RMII serializer
`define BR_MAC_QUEUE_DEPTH 4

// Clock cycles per word at 100 Mbps, 2 bits per cycle
`define BR_WORD_PERIOD 16

// Idle cycles after each frame, 96 bit times
`define BR_IFG_CYCLES 48

`endif

//--- common/eth_bridge_pkg.sv
package eth_bridge_pkg;

	//////////////////////////////////////////////////////////////////////
	// Frame and word types

	// Frame length in bytes, enough for a 1518 byte frame
	typedef logic [10:0] frame_len_t;

	// Valid bytes in one bus word, 0 to 4
	typedef logic [2:0] byte_count_t;

	// One bus word
	// First byte on the wire sits in bits 7:0
	typedef logic [31:0] word_t;

	// Word address into the frame store
	typedef logic [9:0] word_addr_t;

	// Saturating count of refused or rolled back frames
	typedef logic [15:0] drop_count_t;

	//////////////////////////////////////////////////////////////////////
	// MAC side

	// Entry of the word queue in front of the serializer
	typedef struct packed {
		// Payload word
		word_t data;
		// Bytes of it that go on the wire
		byte_count_t bytes_valid;
	} mac_word_t;

endpackage

//--- common/eth_word_if.sv
`timescale 1ns/10ps

interface eth_word_if;
	import eth_bridge_pkg::*;

	// Pulse one cycle before the first word
	logic start;
	// Pulse per word
	logic data_valid;
	// Bytes used in this word
	byte_count_t bytes_valid;
	// Word itself, first byte low
	word_t data;

	// Word producer
	modport source (
		output start,
		output data_valid,
		output bytes_valid,
		output data
	);

	// Word consumer
	modport sink (
		input start,
		input data_valid,
		input bytes_valid,
		input data
	);

endinterface

//--- verilog/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk_50mhz,
	input logic reset,
	input logic wr_en,
	input payload_t wr_data,
	input logic rd_en,
	output payload_t rd_data,
	output logic full,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// Overflow and underflow requests are ignored
	assign push = wr_en && !full;
	assign pop = rd_en && !empty;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Head entry shows while not empty
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk_50mhz) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap at DEPTH, not at a power of two
	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Producer must respect full, consumer must respect empty
	assert property (@(posedge clk_50mhz) disable iff (reset) !(wr_en && full));
	assert property (@(posedge clk_50mhz) disable iff (reset) !(rd_en && empty));

endmodule

//--- verilog/rmii_bridge/frame_buffer.sv
`timescale 1ns/10ps
`include "eth_bridge_cfg.svh"

module frame_buffer (
	input logic clk_50mhz,
	input logic reset,
	input logic host_start,
	input logic host_data_valid,
	input eth_bridge_pkg::word_t host_data,
	input eth_bridge_pkg::byte_count_t host_bytes_valid,
	input logic host_commit,
	input logic host_drop,
	input logic len_pop,
	output logic len_empty,
	output eth_bridge_pkg::frame_len_t len_data,
	input logic rd_en,
	input eth_bridge_pkg::word_addr_t rd_offset,
	output eth_bridge_pkg::word_t rd_data,
	input logic pop_frame,
	input eth_bridge_pkg::word_addr_t pop_words,
	output eth_bridge_pkg::drop_count_t drop_count
);
	import eth_bridge_pkg::*;

	// One extra pointer bit so a full store differs from an empty one
	localparam int PTR_W = $clog2(`BR_BUF_WORDS) + 1;

	word_t mem [`BR_BUF_WORDS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] wr_commit;
	logic [PTR_W-1:0] rd_base;
	logic [PTR_W-1:0] used_words;
	logic [PTR_W-1:0] committed_words;
	logic [PTR_W-1:0] free_words;
	word_addr_t rd_addr;
	word_t rd_q;
	frame_len_t wr_len;
	logic dropping;
	logic refuse;
	logic wr_accept;
	logic len_push;
	logic len_full;

	//////////////////////////////////////////////////////////////////////
	// Write side

	// Space counts against the tentative pointer
	assign used_words = wr_ptr - rd_base;
	assign committed_words = wr_commit - rd_base;
	assign free_words = PTR_W'(`BR_BUF_WORDS) - used_words;

	// Room for a worst case frame and a free length slot, or refuse it
	assign refuse = (free_words < PTR_W'(`BR_MAX_FRAME_WORDS)) || len_full;

	assign wr_accept = host_data_valid && !dropping;
	assign len_push = host_commit && !dropping;

	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			wr_ptr <= '0;
			wr_commit <= '0;
			rd_base <= '0;
			wr_len <= '0;
			dropping <= 1'b0;
		end else begin
			// Decision holds for the whole frame
			if (host_start) begin
				dropping <= refuse;
				wr_len <= '0;
			end
			if (wr_accept) begin
				wr_ptr <= wr_ptr + 1'b1;
				wr_len <= wr_len + frame_len_t'(host_bytes_valid);
			end
			if (len_push)
				wr_commit <= wr_ptr;
			// Rollback, forget everything since the last commit
			if (host_drop && !dropping)
				wr_ptr <= wr_commit;
			if (pop_frame)
				rd_base <= rd_base + PTR_W'(pop_words);
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (wr_accept)
			mem[wr_ptr[PTR_W-2:0]] <= host_data;
	end

	// Refused at start or rolled back, each counted once
	always_ff @(posedge clk_50mhz) begin
		if (reset)
			drop_count <= '0;
		else if ((host_start && refuse) || (host_drop && !dropping)) begin
			if (drop_count != '1)
				drop_count <= drop_count + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Length queue

	sync_fifo #(
		.payload_t(frame_len_t),
		.DEPTH(`BR_LEN_DEPTH)
	) len_fifo_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.wr_en(len_push),
		.wr_data(wr_len),
		.rd_en(len_pop),
		.rd_data(len_data),
		.full(len_full),
		.empty(len_empty)
	);

	//////////////////////////////////////////////////////////////////////
	// Read side

	// Offset from the oldest frame, wraps with the store
	assign rd_addr = rd_base[PTR_W-2:0] + rd_offset;

	always_ff @(posedge clk_50mhz) begin
		if (rd_en)
			rd_q <= mem[rd_addr];
	end

	assign rd_data = rd_q;

	// Reader may only free words of frames already committed
	assert property (@(posedge clk_50mhz) disable iff (reset)
		pop_frame |-> (PTR_W'(pop_words) <= committed_words));

endmodule

//--- verilog/rmii_bridge/frame_reader.sv
`timescale 1ns/10ps
`include "eth_bridge_cfg.svh"

module frame_reader (
	input logic clk_50mhz,
	input logic reset,
	input logic len_empty,
	input eth_bridge_pkg::frame_len_t len_data,
	output logic len_pop,
	output logic rd_en,
	output eth_bridge_pkg::word_addr_t rd_offset,
	input eth_bridge_pkg::word_t rd_data,
	output logic pop_frame,
	output eth_bridge_pkg::word_addr_t pop_words,
	input logic mac_busy,
	eth_word_if.source tx
);
	import eth_bridge_pkg::*;

	localparam int CNT_W = $clog2(`BR_WORD_PERIOD);
	// Fetch one cycle early so the word is ready at the period edge
	localparam logic [CNT_W-1:0] PREFETCH_AT = CNT_W'(`BR_WORD_PERIOD - 2);
	localparam logic [CNT_W-1:0] DECIDE_AT = CNT_W'(`BR_WORD_PERIOD - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LEN_WAIT,
		ST_DATA_WAIT,
		ST_WORD,
		ST_COUNT
	} state_t;

	state_t state;
	logic [CNT_W-1:0] count;
	frame_len_t frame_len;
	frame_len_t bytes_left;
	logic take_len;
	logic prefetch;
	logic decide;

	// New frame only once the MAC has finished its gap
	assign take_len = (state == ST_IDLE) && !len_empty && !mac_busy;
	assign prefetch = (state == ST_COUNT) && (count == PREFETCH_AT) && (bytes_left != '0);
	assign decide = (state == ST_COUNT) && (count == DECIDE_AT);

	//////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			state <= ST_IDLE;
			count <= '0;
			len_pop <= 1'b0;
			rd_en <= 1'b0;
			pop_frame <= 1'b0;
			tx.start <= 1'b0;
			tx.data_valid <= 1'b0;
		end else begin
			// Strobes are single cycle
			len_pop <= 1'b0;
			rd_en <= 1'b0;
			pop_frame <= 1'b0;
			tx.start <= 1'b0;
			tx.data_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (take_len) begin
						len_pop <= 1'b1;
						state <= ST_LEN_WAIT;
					end
				end
				// First word is always there once a length is queued
				ST_LEN_WAIT: begin
					rd_en <= 1'b1;
					tx.start <= 1'b1;
					state <= ST_DATA_WAIT;
				end
				ST_DATA_WAIT: begin
					count <= '0;
					state <= ST_WORD;
				end
				ST_WORD: begin
					tx.data_valid <= 1'b1;
					count <= count + 1'b1;
					state <= ST_COUNT;
				end
				ST_COUNT: begin
					count <= count + 1'b1;
					if (prefetch)
						rd_en <= 1'b1;
					if (decide) begin
						if (bytes_left == '0) begin
							pop_frame <= 1'b1;
							state <= ST_IDLE;
						end else
							state <= ST_WORD;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath

	always_ff @(posedge clk_50mhz) begin
		if (take_len) begin
			frame_len <= len_data;
			bytes_left <= len_data;
		end
		if (state == ST_LEN_WAIT)
			rd_offset <= '0;
		if (prefetch)
			rd_offset <= rd_offset + 1'b1;
		// Up to four bytes per word, remainder in the last one
		if (state == ST_WORD) begin
			tx.data <= rd_data;
			if (bytes_left > frame_len_t'(4)) begin
				tx.bytes_valid <= 3'd4;
				bytes_left <= bytes_left - frame_len_t'(4);
			end else begin
				tx.bytes_valid <= byte_count_t'(bytes_left);
				bytes_left <= '0;
			end
		end
		// Words used by the frame, rounded up
		if (decide)
			pop_words <= word_addr_t'(frame_len[10:2]) + word_addr_t'(frame_len[1:0] != 2'b00);
	end

endmodule

//--- verilog/rmii_tx_mac.sv
`timescale 1ns/10ps
`include "eth_bridge_cfg.svh"

module rmii_tx_mac (
	input logic clk_50mhz,
	input logic reset,
	eth_word_if.sink tx,
	output logic mac_busy,
	output logic rmii_rx_en,
	output logic [1:0] rmii_rxd
);
	import eth_bridge_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_DATA,
		ST_FCS,
		ST_GAP
	} state_t;

	state_t state;
	// Shared by preamble, data position, FCS and gap
	logic [5:0] cnt;
	mac_word_t q_head;
	mac_word_t cur;
	logic q_empty;
	logic q_rd;
	logic word_done;
	logic [7:0] cur_byte;
	logic [31:0] crc;
	logic [31:0] fcs;

	// Reflected CRC-32, one byte, LSB first
	function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++)
			r = (r >> 1) ^ ((r[0] ^ b[i]) ? 32'hedb88320 : 32'h0);
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Word queue

	sync_fifo #(
		.payload_t(mac_word_t),
		.DEPTH(`BR_MAC_QUEUE_DEPTH)
	) word_fifo_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.wr_en(tx.data_valid),
		.wr_data('{data: tx.data, bytes_valid: tx.bytes_valid}),
		.rd_en(q_rd),
		.rd_data(q_head),
		.full(),
		.empty(q_empty)
	);

	// cnt[3:2] is the byte, cnt[1:0] the dibit within it
	assign cur_byte = cur.data[{cnt[3:2], 3'b000} +: 8];
	assign word_done = (state == ST_DATA) && (cnt[1:0] == 2'd3) &&
		((3'(cnt[3:2]) + 3'd1) == cur.bytes_valid);

	// A short word ends the frame, so does a full one with nothing behind it
	assign q_rd = ((state == ST_PREAMBLE) && (cnt == 6'd31)) ||
		(word_done && (cur.bytes_valid == 3'd4) && !q_empty);

	assign fcs = ~crc;
	assign mac_busy = (state != ST_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Line sequencer

	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			state <= ST_IDLE;
			cnt <= '0;
			rmii_rx_en <= 1'b0;
			rmii_rxd <= 2'b00;
		end else begin
			case (state)
				ST_IDLE: begin
					rmii_rx_en <= 1'b0;
					rmii_rxd <= 2'b00;
					cnt <= '0;
					if (tx.start)
						state <= ST_PREAMBLE;
				end
				// Seven 0x55 then 0xD5, last dibit of SFD is 11
				ST_PREAMBLE: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd <= (cnt == 6'd31) ? 2'b11 : 2'b01;
					cnt <= cnt + 1'b1;
					if (cnt == 6'd31) begin
						cnt <= '0;
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					rmii_rxd <= cur.data[{cnt[3:0], 1'b0} +: 2];
					cnt <= cnt + 1'b1;
					if (word_done) begin
						cnt <= '0;
						if (!q_rd)
							state <= ST_FCS;
					end
				end
				ST_FCS: begin
					rmii_rxd <= fcs[{cnt[3:0], 1'b0} +: 2];
					cnt <= cnt + 1'b1;
					if (cnt == 6'd15) begin
						cnt <= '0;
						state <= ST_GAP;
					end
				end
				// Line idle, still busy until the gap has run out
				ST_GAP: begin
					rmii_rx_en <= 1'b0;
					rmii_rxd <= 2'b00;
					cnt <= cnt + 1'b1;
					if (cnt == 6'(`BR_IFG_CYCLES))
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Current word and CRC

	always_ff @(posedge clk_50mhz) begin
		if (q_rd)
			cur <= q_head;
		if (state == ST_IDLE && tx.start)
			crc <= '1;
		// Fold each byte in on its last dibit
		else if (state == ST_DATA && cnt[1:0] == 2'd3)
			crc <= crc32_byte(crc, cur_byte);
	end

	// Reader pacing must keep a word queued ahead of the serializer
	assert property (@(posedge clk_50mhz) disable iff (reset)
		(state == ST_PREAMBLE && cnt == 6'd31) |-> !q_empty);

endmodule

//--- verilog/rmii_bridge_top.sv
`timescale 1ns/10ps

module rmii_bridge_top (
	input logic clk_50mhz,
	input logic reset,
	input logic host_start,
	input logic host_data_valid,
	input eth_bridge_pkg::byte_count_t host_bytes_valid,
	input eth_bridge_pkg::word_t host_data,
	input logic host_commit,
	input logic host_drop,
	output logic rmii_refclk,
	output logic rmii_rx_en,
	output logic [1:0] rmii_rxd,
	output eth_bridge_pkg::drop_count_t drop_count
);
	import eth_bridge_pkg::*;

	logic len_empty;
	frame_len_t len_data;
	logic len_pop;
	logic rd_en;
	word_addr_t rd_offset;
	word_t rd_data;
	logic pop_frame;
	word_addr_t pop_words;
	logic mac_busy;

	eth_word_if mac_tx ();

	// Data changes on the rising edge, so the far end samples mid-bit
	assign rmii_refclk = ~clk_50mhz;

	//////////////////////////////////////////////////////////////////////
	// Store, reader, serializer

	frame_buffer frame_buffer_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.host_start(host_start),
		.host_data_valid(host_data_valid),
		.host_data(host_data),
		.host_bytes_valid(host_bytes_valid),
		.host_commit(host_commit),
		.host_drop(host_drop),
		.len_pop(len_pop),
		.len_empty(len_empty),
		.len_data(len_data),
		.rd_en(rd_en),
		.rd_offset(rd_offset),
		.rd_data(rd_data),
		.pop_frame(pop_frame),
		.pop_words(pop_words),
		.drop_count(drop_count)
	);

	frame_reader frame_reader_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.len_empty(len_empty),
		.len_data(len_data),
		.len_pop(len_pop),
		.rd_en(rd_en),
		.rd_offset(rd_offset),
		.rd_data(rd_data),
		.pop_frame(pop_frame),
		.pop_words(pop_words),
		.mac_busy(mac_busy),
		.tx(mac_tx.source)
	);

	rmii_tx_mac rmii_tx_mac_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.tx(mac_tx.sink),
		.mac_busy(mac_busy),
		.rmii_rx_en(rmii_rx_en),
		.rmii_rxd(rmii_rxd)
	);

endmodule

//--- dv/rmii_bridge_tb.sv
`timescale 1ns/10ps
`include "eth_bridge_cfg.svh"

module rmii_bridge_tb;
	import eth_bridge_pkg::*;

	localparam int NUM_ROWS = 14;
	localparam int DRAIN_TIMEOUT = 40000;
	localparam logic [1:0] MODE_COMMIT = 2'd0;
	localparam logic [1:0] MODE_DROP = 2'd1;
	localparam logic [1:0] MODE_BURST = 2'd2;

	// One stimulus row, sent is the expected outcome on RMII
	typedef struct packed {
		frame_len_t len;
		logic [7:0] seed;
		logic [1:0] mode;
		logic sent;
	} row_t;

	logic clk_50mhz;
	logic reset;
	logic host_start;
	logic host_data_valid;
	byte_count_t host_bytes_valid;
	word_t host_data;
	logic host_commit;
	logic host_drop;
	logic rmii_refclk;
	logic rmii_rx_en;
	logic [1:0] rmii_rxd;
	drop_count_t drop_count;

	row_t rows [NUM_ROWS];
	frame_len_t exp_len [$];
	logic [7:0] exp_seed [$];
	drop_count_t exp_drops = '0;
	int errors = 0;
	int timeouts = 0;

	// Monitor state
	logic [7:0] rx_bytes [$];
	logic [7:0] rx_byte = '0;
	int dibit_cnt = 0;
	int idle_cycles = 0;
	int frames_seen = 0;
	logic was_en = 1'b0;

	rmii_bridge_top rmii_bridge_top_i (
		.clk_50mhz(clk_50mhz),
		.reset(reset),
		.host_start(host_start),
		.host_data_valid(host_data_valid),
		.host_bytes_valid(host_bytes_valid),
		.host_data(host_data),
		.host_commit(host_commit),
		.host_drop(host_drop),
		.rmii_refclk(rmii_refclk),
		.rmii_rx_en(rmii_rx_en),
		.rmii_rxd(rmii_rxd),
		.drop_count(drop_count)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and reference model

	task automatic check_byte(input string name, input int idx, input word_t got,
		input word_t exp);
		if (got !== exp) begin
			$display("** Error %s[%0d] got %h expected %h", name, idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input drop_count_t got, input drop_count_t exp);
		if (got !== exp) begin
			$display("** Error drop_count got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_gap(input int idle);
		if (idle < `BR_IFG_CYCLES) begin
			$display("** Error rmii_rx_en idle gap got %h expected at least %h",
				idle, `BR_IFG_CYCLES);
			errors++;
		end
	endtask

	// MSB first CRC-32 on the plain polynomial, bit reversed for the wire
	function automatic logic [31:0] fcs_model(input frame_len_t len, input logic [7:0] seed);
		logic [31:0] c;
		logic [31:0] r;
		logic [7:0] b;
		logic fb;
		int k;
		int j;
		c = 32'hffffffff;
		for (k = 0; k < len; k++) begin
			b = seed + 8'(k);
			// Each byte goes LSB first
			for (j = 0; j < 8; j++) begin
				fb = c[31] ^ b[j];
				c = c << 1;
				if (fb)
					c = c ^ 32'h04c11db7;
			end
		end
		c = ~c;
		for (j = 0; j < 32; j++)
			r[j] = c[31 - j];
		return r;
	endfunction

	// Compare the assembled bytes with the oldest expected frame
	task automatic check_frame();
		frame_len_t len;
		logic [7:0] seed;
		logic [7:0] exp_bytes [$];
		logic [31:0] fcs;
		int err_before;
		int i;
		if (exp_len.size() == 0)
			return;
		len = exp_len.pop_front();
		seed = exp_seed.pop_front();
		for (i = 0; i < 7; i++)
			exp_bytes.push_back(8'h55);
		exp_bytes.push_back(8'hd5);
		for (i = 0; i < len; i++)
			exp_bytes.push_back(seed + 8'(i));
		fcs = fcs_model(len, seed);
		for (i = 0; i < 4; i++)
			exp_bytes.push_back(fcs[8*i +: 8]);
		if (dibit_cnt != 0) begin
			$display("Frame on RMII ended in the middle of a byte");
			errors++;
		end
		if (rx_bytes.size() != exp_bytes.size()) begin
			$display("Frame on RMII had %0d bytes where %0d were expected",
				rx_bytes.size(), exp_bytes.size());
			errors++;
		end else begin
			// First wrong byte is enough per frame
			err_before = errors;
			for (i = 0; i < exp_bytes.size() && errors == err_before; i++)
				check_byte("rmii_frame_byte", i, word_t'(rx_bytes[i]), word_t'(exp_bytes[i]));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// RMII monitor, samples mid cycle

	always @(negedge clk_50mhz) begin
		if (!reset) begin
			if (rmii_rx_en) begin
				// Rising edge of rx_en opens a new frame
				if (!was_en) begin
					if (frames_seen > 0)
						check_gap(idle_cycles);
					if (exp_len.size() == 0) begin
						$display("Frame started on RMII while none was expected");
						errors++;
					end
					rx_bytes.delete();
					dibit_cnt = 0;
					rx_byte = '0;
				end
				// Low dibit first
				rx_byte[2*dibit_cnt +: 2] = rmii_rxd;
				dibit_cnt++;
				if (dibit_cnt == 4) begin
					rx_bytes.push_back(rx_byte);
					dibit_cnt = 0;
					rx_byte = '0;
				end
				idle_cycles = 0;
			end else begin
				if (was_en) begin
					frames_seen++;
					check_frame();
				end
				idle_cycles++;
			end
			was_en = rmii_rx_en;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Host driver

	task automatic drive_frame(input frame_len_t len, input logic [7:0] seed,
		input logic do_drop);
		int nwords;
		int w;
		int b;
		int left;
		word_t data;
		nwords = (len + 3) / 4;
		@(posedge clk_50mhz);
		#1 host_start = 1'b1;
		@(posedge clk_50mhz);
		#1 host_start = 1'b0;
		for (w = 0; w < nwords; w++) begin
			left = len - 4 * w;
			data = '0;
			// Bytes past the end stay zero
			for (b = 0; b < 4; b++)
				if (b < left)
					data[8*b +: 8] = seed + 8'(4 * w + b);
			host_data_valid = 1'b1;
			host_data = data;
			host_bytes_valid = (left >= 4) ? 3'd4 : byte_count_t'(left);
			@(posedge clk_50mhz);
			#1;
		end
		host_data_valid = 1'b0;
		host_data = '0;
		host_bytes_valid = '0;
		if (do_drop)
			host_drop = 1'b1;
		else
			host_commit = 1'b1;
		@(posedge clk_50mhz);
		#1;
		host_drop = 1'b0;
		host_commit = 1'b0;
	endtask

	// Until every expected frame has left the port
	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((exp_len.size() != 0 || rmii_rx_en) && cycles < DRAIN_TIMEOUT) begin
			@(posedge clk_50mhz);
			cycles++;
		end
		if (exp_len.size() != 0 || rmii_rx_en) begin
			$display("Timed out with %0d frames still to leave the RMII port", exp_len.size());
			timeouts++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		row_t row;
		int gap;
		int r;
		int i;
		void'($urandom(32'hd9ef));
		reset = 1'b1;
		host_start = 1'b0;
		host_data_valid = 1'b0;
		host_bytes_valid = '0;
		host_data = '0;
		host_commit = 1'b0;
		host_drop = 1'b0;

		// Short frames back to back, a rollback, growing sizes
		rows[0] = {11'd60, 8'h10, MODE_COMMIT, 1'b1};
		rows[1] = {11'd61, 8'h20, MODE_COMMIT, 1'b1};
		rows[2] = {11'd62, 8'h30, MODE_COMMIT, 1'b1};
		rows[3] = {11'd63, 8'h40, MODE_COMMIT, 1'b1};
		rows[4] = {11'd100, 8'h50, MODE_DROP, 1'b0};
		rows[5] = {11'd64, 8'h60, MODE_COMMIT, 1'b1};
		rows[6] = {11'd127, 8'h70, MODE_COMMIT, 1'b1};
		rows[7] = {11'd255, 8'h80, MODE_COMMIT, 1'b1};
		rows[8] = {11'd518, 8'h90, MODE_DROP, 1'b0};
		rows[9] = {11'd1023, 8'ha0, MODE_COMMIT, 1'b1};
		rows[10] = {11'd1500, 8'hb0, MODE_COMMIT, 1'b1};
		// Three full size frames, the third finds too little space
		rows[11] = {11'd1500, 8'hc0, MODE_BURST, 1'b1};
		rows[12] = {11'd1500, 8'hd0, MODE_BURST, 1'b1};
		rows[13] = {11'd1500, 8'he0, MODE_BURST, 1'b0};

		repeat (10) @(posedge clk_50mhz);
		#1 reset = 1'b0;

		// Quiet line and clear counter before any host traffic
		for (i = 0; i < 20; i++) begin
			@(negedge clk_50mhz);
			check_byte("rmii_rx_en", i, word_t'(rmii_rx_en), '0);
			check_byte("rmii_rxd", i, word_t'(rmii_rxd), '0);
			check_count(drop_count, '0);
			// Reference clock runs opposite to the core clock
			#5;
			check_byte("rmii_refclk", i, word_t'(rmii_refclk), word_t'(1));
			@(posedge clk_50mhz);
			#5;
			check_byte("rmii_refclk", i, word_t'(rmii_refclk), word_t'(0));
		end

		for (r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
			row = rows[r];
			// A burst starts on an empty store
			if (row.mode == MODE_BURST && (r == 0 || rows[r-1].mode != MODE_BURST))
				wait_drained();
			if (timeouts == 0) begin
				if (row.sent) begin
					exp_len.push_back(row.len);
					exp_seed.push_back(row.seed);
				end else
					exp_drops++;
				drive_frame(row.len, row.seed, row.mode == MODE_DROP);
				@(negedge clk_50mhz);
				check_count(drop_count, exp_drops);
				if (row.mode != MODE_BURST) begin
					gap = $urandom % 8;
					repeat (gap) @(posedge clk_50mhz);
				end
			end
		end

		if (timeouts == 0)
			wait_drained();
		// Room for a stray frame to show up
		repeat (300) @(negedge clk_50mhz);
		check_count(drop_count, exp_drops);

		$display("Frames seen %0d, errors %0d, timeouts %0d", frames_seen, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+common
common/eth_bridge_pkg.sv
common/eth_word_if.sv
verilog/sync_fifo.sv
verilog/rmii_bridge/frame_buffer.sv
verilog/rmii_bridge/frame_reader.sv
verilog/rmii_tx_mac.sv
verilog/rmii_bridge_top.sv
dv/rmii_bridge_tb.sv

//--- Bender.yml
package:
  name: rmii_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/eth_bridge_pkg.sv
      - common/eth_word_if.sv
      - verilog/sync_fifo.sv
      - verilog/rmii_bridge/frame_buffer.sv
      - verilog/rmii_bridge/frame_reader.sv
      - verilog/rmii_tx_mac.sv
      - verilog/rmii_bridge_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/rmii_bridge_tb.sv
